//--- design/mips_pkg.sv
package mips_pkg;

    localparam int NB_DATA = 32;  // Data, instruction and PC width
    localparam int NB_REG  = 5;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b,
        OP_HALT  = 6'h3f
    } opcode_e;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

endpackage

//--- design/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage
    import mips_pkg::*;
#(
    parameter int IM_ADDR_BITS = 8
) (
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic                    i_pc_enable,
    input  logic                    i_im_write_enable,
    input  logic [IM_ADDR_BITS-1:0] i_im_address,
    input  logic [NB_DATA-1:0]      i_im_data,
    input  logic                    i_branch_taken,
    input  logic [NB_DATA-1:0]      i_branch_target,
    input  logic                    i_halt,
    output logic [NB_DATA-1:0]      o_instruction,
    output logic [NB_DATA-1:0]      o_pc_plus4,
    output logic [NB_DATA-1:0]      o_pc
);

    logic [NB_DATA-1:0] imem [2**IM_ADDR_BITS];
    logic [NB_DATA-1:0] pc;
    logic [NB_DATA-1:0] pc_plus4;
    logic [NB_DATA-1:0] pc_next;

    assign pc_plus4 = pc + NB_DATA'(4);
    assign o_pc     = pc;

    always_comb begin
        if (i_halt) begin
            pc_next = pc;               // Frozen once HALT is decoded
        end else if (i_branch_taken) begin
            pc_next = i_branch_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    // Program loader from the debug side
    always_ff @(posedge i_clock) begin
        if (i_im_write_enable && !i_pc_enable) begin
            imem[i_im_address] <= i_im_data;
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc            <= '0;
            o_instruction <= '0;
        end else if (i_pc_enable) begin
            pc            <= pc_next;
            o_instruction <= i_halt ? '0 : imem[pc[IM_ADDR_BITS+1:2]];  // NOP bubbles
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_pc_enable) begin
            o_pc_plus4 <= pc_plus4;
        end
    end

    // Loader and pipeline must never run together
    assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_im_write_enable |-> !i_pc_enable)
        else $error("Instruction memory written while the pipeline is enabled");

endmodule

//--- design/register_file.sv
`timescale 1ns/1ns

module register_file
    import mips_pkg::*;
(
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  logic               i_write_enable,
    input  logic [NB_REG-1:0]  i_write_reg,
    input  logic [NB_DATA-1:0] i_write_data,
    input  logic [NB_REG-1:0]  i_read_reg_a,
    input  logic [NB_REG-1:0]  i_read_reg_b,
    input  logic [NB_REG-1:0]  i_debug_reg,
    output logic [NB_DATA-1:0] o_data_a,
    output logic [NB_DATA-1:0] o_data_b,
    output logic [NB_DATA-1:0] o_debug_data
);

    logic [NB_DATA-1:0] regs [32];

    // Write-through so decode sees a write-back in the same cycle
    assign o_data_a = (i_read_reg_a == '0) ? '0 :
                      (i_write_enable && i_write_reg == i_read_reg_a) ? i_write_data :
                      regs[i_read_reg_a];
    assign o_data_b = (i_read_reg_b == '0) ? '0 :
                      (i_write_enable && i_write_reg == i_read_reg_b) ? i_write_data :
                      regs[i_read_reg_b];

    assign o_debug_data = regs[i_debug_reg];

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_write_enable && i_write_reg != '0) begin
            regs[i_write_reg] <= i_write_data;
        end
    end

    assert property (@(posedge i_clock) disable iff (!i_rst_n)
        regs[0] == '0)
        else $error("Register zero holds a nonzero value");

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ns

module decode_stage
    import mips_pkg::*;
(
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  logic               i_pc_enable,
    input  logic [NB_DATA-1:0] i_instruction,
    input  logic [NB_DATA-1:0] i_pc_plus4,
    input  logic [NB_DATA-1:0] i_data_a,
    input  logic [NB_DATA-1:0] i_data_b,
    output logic [NB_REG-1:0]  o_read_reg_a,
    output logic [NB_REG-1:0]  o_read_reg_b,
    output logic [NB_REG-1:0]  o_dest_reg,
    output alu_op_e            o_alu_op,
    output logic               o_alu_src,
    output logic               o_reg_write,
    output logic               o_mem_read,
    output logic               o_mem_write,
    output logic               o_mem_to_reg,
    output logic               o_branch,
    output logic               o_halt_marker,
    output logic               o_halt,
    output logic [NB_DATA-1:0] o_data_a,
    output logic [NB_DATA-1:0] o_data_b,
    output logic [NB_DATA-1:0] o_immediate,
    output logic [NB_DATA-1:0] o_pc_plus4
);

    opcode_e            opcode;
    funct_e             funct;
    alu_op_e            alu_op;
    logic [NB_DATA-1:0] imm_ext;
    logic               alu_src;
    logic               reg_write;
    logic               mem_read;
    logic               mem_write;
    logic               mem_to_reg;
    logic               branch;
    logic               use_rd;
    logic               is_halt;
    logic               halt_seen;

    assign opcode       = opcode_e'(i_instruction[31:26]);
    assign funct        = funct_e'(i_instruction[5:0]);
    assign o_read_reg_a = i_instruction[25:21];
    assign o_read_reg_b = i_instruction[20:16];
    assign imm_ext      = {{16{i_instruction[15]}}, i_instruction[15:0]};
    assign is_halt      = (opcode == OP_HALT);
    assign o_halt       = is_halt || halt_seen;  // Back to fetch

    always_comb begin
        alu_op     = ALU_ADD;
        alu_src    = 1'b0;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        branch     = 1'b0;
        use_rd     = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                use_rd    = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: reg_write = 1'b0;  // NOP lands here
                endcase
            end
            OP_ADDI: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            OP_LW: begin
                alu_src    = 1'b1;
                reg_write  = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            OP_BEQ: begin
                alu_op = ALU_SUB;
                branch = 1'b1;
            end
            default: begin
                // HALT and unknown opcodes carry no work
            end
        endcase
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            halt_seen     <= 1'b0;
            o_alu_op      <= ALU_ADD;
            o_alu_src     <= 1'b0;
            o_reg_write   <= 1'b0;
            o_mem_read    <= 1'b0;
            o_mem_write   <= 1'b0;
            o_mem_to_reg  <= 1'b0;
            o_branch      <= 1'b0;
            o_halt_marker <= 1'b0;
        end else if (i_pc_enable) begin
            halt_seen     <= halt_seen || is_halt;
            o_alu_op      <= alu_op;
            o_alu_src     <= alu_src;
            o_reg_write   <= reg_write;
            o_mem_read    <= mem_read;
            o_mem_write   <= mem_write;
            o_mem_to_reg  <= mem_to_reg;
            o_branch      <= branch;
            o_halt_marker <= is_halt;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_pc_enable) begin
            o_dest_reg  <= use_rd ? i_instruction[15:11] : i_instruction[20:16];
            o_data_a    <= i_data_a;
            o_data_b    <= i_data_b;
            o_immediate <= imm_ext;
            o_pc_plus4  <= i_pc_plus4;
        end
    end

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ns

module execute_stage
    import mips_pkg::*;
(
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  logic               i_pc_enable,
    input  logic [NB_REG-1:0]  i_dest_reg,
    input  alu_op_e            i_alu_op,
    input  logic               i_alu_src,
    input  logic               i_reg_write,
    input  logic               i_mem_read,
    input  logic               i_mem_write,
    input  logic               i_mem_to_reg,
    input  logic               i_branch,
    input  logic               i_halt_marker,
    input  logic [NB_DATA-1:0] i_data_a,
    input  logic [NB_DATA-1:0] i_data_b,
    input  logic [NB_DATA-1:0] i_immediate,
    input  logic [NB_DATA-1:0] i_pc_plus4,
    output logic [NB_DATA-1:0] o_alu_result,
    output logic [NB_DATA-1:0] o_store_data,
    output logic [NB_REG-1:0]  o_dest_reg,
    output logic               o_reg_write,
    output logic               o_mem_read,
    output logic               o_mem_write,
    output logic               o_mem_to_reg,
    output logic               o_branch_taken,
    output logic [NB_DATA-1:0] o_branch_target,
    output logic               o_halt_done
);

    logic [NB_DATA-1:0] operand_b;
    logic [NB_DATA-1:0] alu_result;

    assign operand_b = i_alu_src ? i_immediate : i_data_b;

    always_comb begin
        case (i_alu_op)
            ALU_ADD: alu_result = i_data_a + operand_b;
            ALU_SUB: alu_result = i_data_a - operand_b;
            ALU_AND: alu_result = i_data_a & operand_b;
            ALU_OR:  alu_result = i_data_a | operand_b;
            ALU_SLT: alu_result = NB_DATA'($signed(i_data_a) < $signed(operand_b));
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_reg_write    <= 1'b0;
            o_mem_read     <= 1'b0;
            o_mem_write    <= 1'b0;
            o_mem_to_reg   <= 1'b0;
            o_branch_taken <= 1'b0;
            o_halt_done    <= 1'b0;
        end else if (i_pc_enable) begin
            o_reg_write    <= i_reg_write;
            o_mem_read     <= i_mem_read;
            o_mem_write    <= i_mem_write;
            o_mem_to_reg   <= i_mem_to_reg;
            o_branch_taken <= i_branch && (i_data_a == i_data_b);  // Fetch reacts next edge
            o_halt_done    <= i_halt_marker;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_pc_enable) begin
            o_alu_result    <= alu_result;
            o_store_data    <= i_data_b;
            o_dest_reg      <= i_dest_reg;
            o_branch_target <= i_pc_plus4 + {i_immediate[NB_DATA-3:0], 2'b00};
        end
    end

endmodule

//--- design/memory_stage.sv
`timescale 1ns/1ns

module memory_stage
    import mips_pkg::*;
#(
    parameter int DM_ADDR_BITS = 7
) (
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic                    i_pc_enable,
    input  logic [NB_DATA-1:0]      i_alu_result,
    input  logic [NB_DATA-1:0]      i_store_data,
    input  logic [NB_REG-1:0]       i_dest_reg,
    input  logic                    i_reg_write,
    input  logic                    i_mem_read,
    input  logic                    i_mem_write,
    input  logic                    i_mem_to_reg,
    input  logic                    i_halt_done,
    input  logic [DM_ADDR_BITS-1:0] i_dm_address,
    output logic                    o_wb_write_enable,
    output logic [NB_REG-1:0]       o_wb_reg,
    output logic [NB_DATA-1:0]      o_wb_data,
    output logic [NB_DATA-1:0]      o_dm_data,
    output logic                    o_hlt
);

    logic [NB_DATA-1:0]      dmem [2**DM_ADDR_BITS];
    logic [DM_ADDR_BITS-1:0] word_addr;
    logic [NB_DATA-1:0]      load_data;

    assign word_addr = i_alu_result[DM_ADDR_BITS+1:2];  // Byte address to word index
    assign load_data = i_mem_read ? dmem[word_addr] : '0;
    assign o_dm_data = dmem[i_dm_address];               // Debug read

    always_ff @(posedge i_clock) begin
        if (i_pc_enable && i_mem_write) begin
            dmem[word_addr] <= i_store_data;
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_write_enable <= 1'b0;
            o_hlt             <= 1'b0;
        end else if (i_pc_enable) begin
            o_wb_write_enable <= i_reg_write;
            if (i_halt_done) begin
                o_hlt <= 1'b1;  // Sticky until reset
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_pc_enable) begin
            o_wb_reg  <= i_dest_reg;
            o_wb_data <= i_mem_to_reg ? load_data : i_alu_result;
        end
    end

    assert property (@(posedge i_clock) disable iff (!i_rst_n)
        (i_pc_enable && (i_mem_read || i_mem_write)) |-> (i_alu_result[1:0] == 2'b00))
        else $error("Unaligned data memory access");

endmodule

//--- design/mips_pipeline_top.sv
`timescale 1ns/1ns

module mips_pipeline_top
    import mips_pkg::*;
#(
    parameter int IM_ADDR_BITS = 8,
    parameter int DM_ADDR_BITS = 7
) (
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic                    i_pc_enable,
    input  logic                    i_im_write_enable,
    input  logic [IM_ADDR_BITS-1:0] i_im_address,
    input  logic [NB_DATA-1:0]      i_im_data,
    input  logic [NB_REG-1:0]       i_rb_address,
    input  logic [DM_ADDR_BITS-1:0] i_dm_address,
    output logic [NB_DATA-1:0]      o_rb_data,
    output logic [NB_DATA-1:0]      o_dm_data,
    output logic [NB_DATA-1:0]      o_pc_value,
    output logic                    o_hlt
);

    // Fetch to decode
    logic [NB_DATA-1:0] if_instruction;
    logic [NB_DATA-1:0] if_pc_plus4;

    // Decode and register file
    logic [NB_REG-1:0]  rs_index;
    logic [NB_REG-1:0]  rt_index;
    logic [NB_DATA-1:0] rf_data_a;
    logic [NB_DATA-1:0] rf_data_b;
    logic [NB_REG-1:0]  id_dest_reg;
    alu_op_e            id_alu_op;
    logic               id_alu_src;
    logic               id_reg_write;
    logic               id_mem_read;
    logic               id_mem_write;
    logic               id_mem_to_reg;
    logic               id_branch;
    logic               id_halt_marker;
    logic               id_halt;
    logic [NB_DATA-1:0] id_data_a;
    logic [NB_DATA-1:0] id_data_b;
    logic [NB_DATA-1:0] id_immediate;
    logic [NB_DATA-1:0] id_pc_plus4;

    // Execute to memory, branch back to fetch
    logic [NB_DATA-1:0] ex_alu_result;
    logic [NB_DATA-1:0] ex_store_data;
    logic [NB_REG-1:0]  ex_dest_reg;
    logic               ex_reg_write;
    logic               ex_mem_read;
    logic               ex_mem_write;
    logic               ex_mem_to_reg;
    logic               ex_branch_taken;
    logic [NB_DATA-1:0] ex_branch_target;
    logic               ex_halt_done;

    // Write-back
    logic               wb_write_enable;
    logic [NB_REG-1:0]  wb_reg;
    logic [NB_DATA-1:0] wb_data;

    fetch_stage #(
        .IM_ADDR_BITS(IM_ADDR_BITS)
    ) fetch_stage_inst (
        .i_clock          (i_clock),
        .i_rst_n          (i_rst_n),
        .i_pc_enable      (i_pc_enable),
        .i_im_write_enable(i_im_write_enable),
        .i_im_address     (i_im_address),
        .i_im_data        (i_im_data),
        .i_branch_taken   (ex_branch_taken),
        .i_branch_target  (ex_branch_target),
        .i_halt           (id_halt),
        .o_instruction    (if_instruction),
        .o_pc_plus4       (if_pc_plus4),
        .o_pc             (o_pc_value)
    );

    decode_stage decode_stage_inst (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_pc_enable  (i_pc_enable),
        .i_instruction(if_instruction),
        .i_pc_plus4   (if_pc_plus4),
        .i_data_a     (rf_data_a),
        .i_data_b     (rf_data_b),
        .o_read_reg_a (rs_index),
        .o_read_reg_b (rt_index),
        .o_dest_reg   (id_dest_reg),
        .o_alu_op     (id_alu_op),
        .o_alu_src    (id_alu_src),
        .o_reg_write  (id_reg_write),
        .o_mem_read   (id_mem_read),
        .o_mem_write  (id_mem_write),
        .o_mem_to_reg (id_mem_to_reg),
        .o_branch     (id_branch),
        .o_halt_marker(id_halt_marker),
        .o_halt       (id_halt),
        .o_data_a     (id_data_a),
        .o_data_b     (id_data_b),
        .o_immediate  (id_immediate),
        .o_pc_plus4   (id_pc_plus4)
    );

    register_file register_file_inst (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_write_enable(wb_write_enable),
        .i_write_reg   (wb_reg),
        .i_write_data  (wb_data),
        .i_read_reg_a  (rs_index),
        .i_read_reg_b  (rt_index),
        .i_debug_reg   (i_rb_address),
        .o_data_a      (rf_data_a),
        .o_data_b      (rf_data_b),
        .o_debug_data  (o_rb_data)
    );

    execute_stage execute_stage_inst (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_pc_enable    (i_pc_enable),
        .i_dest_reg     (id_dest_reg),
        .i_alu_op       (id_alu_op),
        .i_alu_src      (id_alu_src),
        .i_reg_write    (id_reg_write),
        .i_mem_read     (id_mem_read),
        .i_mem_write    (id_mem_write),
        .i_mem_to_reg   (id_mem_to_reg),
        .i_branch       (id_branch),
        .i_halt_marker  (id_halt_marker),
        .i_data_a       (id_data_a),
        .i_data_b       (id_data_b),
        .i_immediate    (id_immediate),
        .i_pc_plus4     (id_pc_plus4),
        .o_alu_result   (ex_alu_result),
        .o_store_data   (ex_store_data),
        .o_dest_reg     (ex_dest_reg),
        .o_reg_write    (ex_reg_write),
        .o_mem_read     (ex_mem_read),
        .o_mem_write    (ex_mem_write),
        .o_mem_to_reg   (ex_mem_to_reg),
        .o_branch_taken (ex_branch_taken),
        .o_branch_target(ex_branch_target),
        .o_halt_done    (ex_halt_done)
    );

    memory_stage #(
        .DM_ADDR_BITS(DM_ADDR_BITS)
    ) memory_stage_inst (
        .i_clock          (i_clock),
        .i_rst_n          (i_rst_n),
        .i_pc_enable      (i_pc_enable),
        .i_alu_result     (ex_alu_result),
        .i_store_data     (ex_store_data),
        .i_dest_reg       (ex_dest_reg),
        .i_reg_write      (ex_reg_write),
        .i_mem_read       (ex_mem_read),
        .i_mem_write      (ex_mem_write),
        .i_mem_to_reg     (ex_mem_to_reg),
        .i_halt_done      (ex_halt_done),
        .i_dm_address     (i_dm_address),
        .o_wb_write_enable(wb_write_enable),
        .o_wb_reg         (wb_reg),
        .o_wb_data        (wb_data),
        .o_dm_data        (o_dm_data),
        .o_hlt            (o_hlt)
    );

endmodule

//--- bench/tb_program_model.svh
// Writes to register zero are dropped
function automatic void set_reg(logic [NB_REG-1:0] r, logic [NB_DATA-1:0] v);
    if (r != '0) begin
        exp_regs[r] = v;
    end
endfunction

// Runs prog[] by the ISA rules, three delay slots after a taken BEQ
function automatic int model_run();
    int                 pc;
    int                 slots;
    int                 target;
    int                 steps;
    logic [NB_DATA-1:0] ins;
    logic [NB_DATA-1:0] a;
    logic [NB_DATA-1:0] b;
    logic [NB_DATA-1:0] imm;
    logic [NB_DATA-1:0] word;
    for (int i = 0; i < 32; i++) begin
        exp_regs[i] = '0;  // DUT is reset before every run
    end
    pc     = 0;
    slots  = -1;
    target = 0;
    steps  = 0;
    while (steps < 1000 && pc < 256 && prog[pc][31:26] != OP_HALT) begin
        ins   = prog[pc];
        a     = exp_regs[ins[25:21]];
        b     = exp_regs[ins[20:16]];
        imm   = {{16{ins[15]}}, ins[15:0]};
        word  = (a + imm) >> 2;
        steps = steps + 1;
        case (ins[31:26])
            OP_RTYPE: begin
                case (ins[5:0])
                    FN_ADDU: set_reg(ins[15:11], a + b);
                    FN_SUBU: set_reg(ins[15:11], a - b);
                    FN_AND:  set_reg(ins[15:11], a & b);
                    FN_OR:   set_reg(ins[15:11], a | b);
                    FN_SLT:  set_reg(ins[15:11], {31'd0, $signed(a) < $signed(b)});
                    default: begin
                    end
                endcase
            end
            OP_ADDI: set_reg(ins[20:16], a + imm);
            OP_LW:   set_reg(ins[20:16], exp_mem[word[6:0]]);
            OP_SW:   exp_mem[word[6:0]] = b;
            OP_BEQ: begin
                if (a == b) begin
                    slots  = 3;
                    target = pc + 1 + int'($signed(imm));
                end
            end
            default: begin
            end
        endcase
        if (slots == 0) begin
            pc    = target;  // Last delay slot done
            slots = -1;
        end else begin
            pc = pc + 1;
            if (slots > 0) begin
                slots = slots - 1;
            end
        end
    end
    return steps;
endfunction

//--- bench/tb_mips_pipeline.sv
`timescale 1ns/1ns

module tb_mips_pipeline
    import mips_pkg::*;
;

    logic               i_clock;
    logic               i_rst_n;
    logic               i_pc_enable;
    logic               i_im_write_enable;
    logic [7:0]         i_im_address;
    logic [NB_DATA-1:0] i_im_data;
    logic [NB_REG-1:0]  i_rb_address;
    logic [6:0]         i_dm_address;
    logic [NB_DATA-1:0] o_rb_data;
    logic [NB_DATA-1:0] o_dm_data;
    logic [NB_DATA-1:0] o_pc_value;
    logic               o_hlt;

    logic [NB_DATA-1:0] prog [256];
    logic [NB_DATA-1:0] exp_regs [32];
    logic [NB_DATA-1:0] exp_mem [128];
    int                 prog_len;
    int                 errors;
    int                 checks;
    int                 tests_failed;
    funct_e             fns [5] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_SLT};

    `include "tb_program_model.svh"

    mips_pipeline_top #(
        .IM_ADDR_BITS(8),
        .DM_ADDR_BITS(7)
    ) mips_pipeline_top_inst (.*);

    initial begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    function automatic logic [NB_DATA-1:0] enc_r(funct_e fn, int rd, int rs, int rt);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [NB_DATA-1:0] enc_i(opcode_e op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic void emit(logic [NB_DATA-1:0] w);
        prog[prog_len] = w;
        prog_len       = prog_len + 1;
    endfunction

    function automatic void emit_group(logic [NB_DATA-1:0] w);
        emit(w);
        for (int i = 0; i < 3; i++) begin
            emit('0);  // NOP padding keeps reads four apart
        end
    endfunction

    task automatic check_value(string name, logic [NB_DATA-1:0] expected,
                               logic [NB_DATA-1:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            $display("ERROR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            errors = errors + 1;
        end
    endtask

    task automatic reset_dut();
        @(negedge i_clock);
        i_rst_n     = 1'b0;
        i_pc_enable = 1'b0;
        repeat (10) @(negedge i_clock);
        i_rst_n = 1'b1;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(negedge i_clock);
            i_im_write_enable = 1'b1;
            i_im_address      = 8'(i);
            i_im_data         = prog[i];
        end
        @(negedge i_clock);
        i_im_write_enable = 1'b0;
    endtask

    task automatic wait_halt(int limit);
        for (int i = 0; i < limit; i++) begin
            @(negedge i_clock);
            if (o_hlt) begin
                break;
            end
        end
        if (!o_hlt) begin
            $display("Timeout, o_hlt did not rise within %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic compare_state();
        for (int r = 0; r < 32; r++) begin
            @(negedge i_clock);
            i_rb_address = 5'(r);
            #1 check_value($sformatf("o_rb_data[%0d]", r), exp_regs[r], o_rb_data);
        end
        for (int w = 0; w < 16; w++) begin  // Words the programs touch
            @(negedge i_clock);
            i_dm_address = 7'(w);
            #1 check_value($sformatf("o_dm_data[%0d]", w), exp_mem[w], o_dm_data);
        end
    endtask

    // Optional pause freezes the pipeline one edge before HALT is fetched
    task automatic run_test(int num, string label, bit pause);
        int               errs_before;
        logic [NB_DATA-1:0] held_pc;
        errs_before = errors;
        reset_dut();
        load_program();
        void'(model_run());
        i_pc_enable = 1'b1;
        if (pause) begin
            repeat (prog_len - 1) @(negedge i_clock);
            i_pc_enable = 1'b0;
            held_pc     = o_pc_value;
            repeat (8) @(negedge i_clock);  // Long enough for HALT to land if not frozen
            check_value("o_pc_value", held_pc, o_pc_value);
            check_value("o_hlt", '0, {31'd0, o_hlt});
            i_pc_enable = 1'b1;
        end
        wait_halt(2000);
        held_pc = o_pc_value;
        repeat (5) @(negedge i_clock);
        check_value("o_hlt", 1, {31'd0, o_hlt});  // Sticky after more cycles
        check_value("o_pc_value", held_pc, o_pc_value);
        i_pc_enable = 1'b0;
        compare_state();
        if (errors != errs_before) begin
            tests_failed = tests_failed + 1;
        end
        $display("Test %0d %s: %0d errors", num, label, errors - errs_before);
    endtask

    function automatic void build_alu_program();
        prog_len = 0;
        emit_group(enc_i(OP_ADDI, 1, 0, 5));
        emit_group(enc_i(OP_ADDI, 2, 0, -3));
        emit_group(enc_r(FN_ADDU, 3, 1, 2));
        emit_group(enc_r(FN_SUBU, 4, 1, 2));
        emit_group(enc_r(FN_AND, 5, 1, 2));
        emit_group(enc_r(FN_OR, 6, 1, 2));
        emit_group(enc_r(FN_SLT, 7, 2, 1));
        emit_group(enc_i(OP_ADDI, 0, 0, 9));
        emit_group(enc_r(FN_ADDU, 0, 1, 1));
        emit(enc_i(OP_HALT, 0, 0, 0));
    endfunction

    function automatic void build_random_program();
        int      groups;
        int      kind;
        int      k;
        opcode_e mem_op;
        prog_len = 0;
        groups   = 8 + int'($urandom % 8);
        for (int g = 0; g < groups; g++) begin
            kind = int'($urandom % 8);
            if (kind < 5) begin
                emit_group(enc_r(fns[$urandom % 5], int'($urandom % 32),
                                 int'($urandom % 32), int'($urandom % 32)));
            end else if (kind == 5) begin
                emit_group(enc_i(OP_ADDI, int'($urandom % 32), int'($urandom % 32),
                                 int'($urandom % 65536)));
            end else if (kind == 6) begin
                mem_op = OP_LW;
                if ($urandom % 2 != 0) begin
                    mem_op = OP_SW;
                end
                emit_group(enc_i(mem_op, int'($urandom % 32), 0, 4 * int'($urandom % 16)));
            end else begin
                k = 1 + int'($urandom % 3);
                if (g + k > groups) begin
                    k = groups - g;  // Target stays inside the program
                end
                emit_group(enc_i(OP_BEQ, int'($urandom % 4), int'($urandom % 4), 4 * k - 1));
            end
        end
        emit(enc_i(OP_HALT, 0, 0, 0));
    endfunction

    initial begin
        void'($urandom(29876));
        i_rst_n           = 1'b0;
        i_pc_enable       = 1'b0;
        i_im_write_enable = 1'b0;
        i_im_address      = '0;
        i_im_data         = '0;
        i_rb_address      = '0;
        i_dm_address      = '0;
        errors            = 0;
        checks            = 0;
        tests_failed      = 0;

        // Reset state, then zero the data words through a store program
        reset_dut();
        check_value("o_hlt", '0, {31'd0, o_hlt});
        check_value("o_pc_value", '0, o_pc_value);
        prog_len = 0;
        for (int w = 0; w < 16; w++) begin
            emit_group(enc_i(OP_SW, 0, 0, 4 * w));
        end
        emit(enc_i(OP_HALT, 0, 0, 0));
        run_test(1, "reset and memory clear", 1'b0);

        build_alu_program();
        run_test(2, "alu dependencies", 1'b0);

        prog_len = 0;
        emit_group(enc_i(OP_ADDI, 1, 0, 16'h1234));
        emit_group(enc_i(OP_ADDI, 2, 0, -7));
        emit_group(enc_i(OP_SW, 1, 0, 8));
        emit_group(enc_i(OP_SW, 2, 0, 12));
        emit_group(enc_i(OP_SW, 1, 0, 60));
        emit_group(enc_i(OP_LW, 3, 0, 8));
        emit_group(enc_i(OP_LW, 4, 0, 12));
        emit_group(enc_i(OP_LW, 5, 0, 60));
        emit(enc_i(OP_HALT, 0, 0, 0));
        run_test(3, "store and load", 1'b0);

        prog_len = 0;
        emit_group(enc_i(OP_ADDI, 1, 0, 7));
        emit_group(enc_i(OP_ADDI, 2, 0, 7));
        emit(enc_i(OP_BEQ, 2, 1, 5));   // Taken branch skips two words
        emit(enc_i(OP_ADDI, 10, 0, 1));
        emit(enc_i(OP_ADDI, 11, 0, 2));
        emit(enc_i(OP_ADDI, 12, 0, 3));
        emit(enc_i(OP_ADDI, 13, 0, 4));
        emit(enc_i(OP_ADDI, 14, 0, 5));
        emit_group(enc_i(OP_ADDI, 15, 0, 6));
        emit(enc_i(OP_BEQ, 0, 1, 4));   // Not taken
        emit(enc_i(OP_ADDI, 16, 0, 7));
        emit(enc_i(OP_ADDI, 17, 0, 8));
        emit(enc_i(OP_ADDI, 18, 0, 9));
        emit_group(enc_i(OP_ADDI, 19, 0, 10));
        emit(enc_i(OP_HALT, 0, 0, 0));
        run_test(4, "branch delay slots", 1'b0);

        build_alu_program();
        run_test(5, "enable pause", 1'b1);

        for (int t = 0; t < 20; t++) begin
            build_random_program();
            run_test(6 + t, "random program", 1'b0);
        end

        $display("Tests run 25, failed %0d, checks %0d, errors %0d",
                 tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+bench
design/mips_pkg.sv
design/fetch_stage.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/mips_pipeline_top.sv
bench/tb_mips_pipeline.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_mips_pipeline \
    -f all.f -o tb_mips_pipeline
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_mips_pipeline > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
